//--- common/rv32Pkg.sv
package rv32Pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths.
	//////////////////////////////////////////////////////////////////////

	localparam int xlen = 32;   // Data and address width.
	localparam int shamtW = 5;  // Shift amount, low bits of operand b.

	//////////////////////////////////////////////////////////////////////
	// Encodings.
	//////////////////////////////////////////////////////////////////////

	// Major opcodes, instr[6:0].
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opImm    = 7'b0010011,
		opAuipc  = 7'b0010111,
		opStore  = 7'b0100011,
		opOp     = 7'b0110011,
		opLui    = 7'b0110111,
		opBranch = 7'b1100011,
		opJalr   = 7'b1100111,
		opJal    = 7'b1101111
	} opcodeE;

	// ALU operations.
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB  // LUI only.
	} aluOpE;

	// Branch conditions, evaluated on a and b.
	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLt,
		brGe,
		brLtu,
		brGeu,
		brJump  // JAL and JALR, always taken.
	} branchOpE;

	// funct3 for OP and OP-IMM.
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Srl    = 3'b101;  // SRA too, by funct7 bit 5.
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// funct3 for branches.
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

endpackage

//--- common/exCtlIf.sv
`timescale 1ns/1ps

// Decoded controls, decoder to ALU and result stage.
interface exCtlIf;
	import rv32Pkg::*;

	aluOpE            aluOp;
	branchOpE         branchOp;
	logic             srcAPc;   // Operand a is pc.
	logic             srcBImm;  // Operand b is imm.
	logic [xlen-1:0]  imm;      // Sign-extended immediate.
	logic             linkPc;   // Write back pc + 4.
	logic             jumpReg;  // JALR.
	logic             illegal;

	modport decoder (
		output aluOp, branchOp, srcAPc, srcBImm, imm, linkPc, jumpReg, illegal
	);

	modport consumer (
		input aluOp, branchOp, srcAPc, srcBImm, imm, linkPc, jumpReg, illegal
	);

endinterface

//--- hw/aluControl.sv
`timescale 1ns/1ps

module aluControl (
	input  logic [rv32Pkg::xlen-1:0] instr,
	exCtlIf.decoder                   ctl
);
	import rv32Pkg::*;

	opcodeE          opcode;
	logic [2:0]      funct3;
	logic            funct7b5;
	logic            useAlt;    // SUB or SRA variant.
	aluOpE           arithOp;   // Shared by OP and OP-IMM.
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;

	assign opcode   = opcodeE'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign funct7b5 = instr[30];

	//////////////////////////////////////////////////////////////////////
	// Immediates.
	//////////////////////////////////////////////////////////////////////

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// OP-IMM has no SUBI; bit 30 there is immediate data except on shifts.
	assign useAlt = funct7b5 && (opcode == opOp || funct3 == f3Srl);

	always_comb begin
		case (funct3)
			f3AddSub: arithOp = useAlt ? aluSub : aluAdd;
			f3Sll:    arithOp = aluSll;
			f3Slt:    arithOp = aluSlt;
			f3Sltu:   arithOp = aluSltu;
			f3Xor:    arithOp = aluXor;
			f3Srl:    arithOp = useAlt ? aluSra : aluSrl;
			f3Or:     arithOp = aluOr;
			default:  arithOp = aluAnd;  // f3And.
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Main decode.
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ctl.aluOp    = aluAdd;  // Also the illegal-case values.
		ctl.branchOp = brNone;
		ctl.srcAPc   = 1'b0;
		ctl.srcBImm  = 1'b0;
		ctl.imm      = immI;
		ctl.linkPc   = 1'b0;
		ctl.jumpReg  = 1'b0;
		ctl.illegal  = 1'b0;
		case (opcode)
			opOp: ctl.aluOp = arithOp;
			opImm: begin
				ctl.aluOp   = arithOp;
				ctl.srcBImm = 1'b1;
			end
			opLui: begin
				ctl.aluOp   = aluPassB;
				ctl.srcBImm = 1'b1;
				ctl.imm     = immU;
			end
			opAuipc: begin
				ctl.srcAPc  = 1'b1;  // pc + U immediate.
				ctl.srcBImm = 1'b1;
				ctl.imm     = immU;
			end
			opJal: begin
				ctl.branchOp = brJump;
				ctl.srcAPc   = 1'b1;
				ctl.srcBImm  = 1'b1;
				ctl.imm      = immJ;
				ctl.linkPc   = 1'b1;
			end
			opJalr: begin
				if (funct3 == 3'b000) begin
					ctl.branchOp = brJump;
					ctl.srcBImm  = 1'b1;  // rs1 + I immediate.
					ctl.linkPc   = 1'b1;
					ctl.jumpReg  = 1'b1;
				end else
					ctl.illegal = 1'b1;
			end
			opBranch: begin
				ctl.aluOp = aluSub;  // rs1 - rs2, a spare value.
				ctl.imm   = immB;
				case (funct3)
					f3Beq:   ctl.branchOp = brEq;
					f3Bne:   ctl.branchOp = brNe;
					f3Blt:   ctl.branchOp = brLt;
					f3Bge:   ctl.branchOp = brGe;
					f3Bltu:  ctl.branchOp = brLtu;
					f3Bgeu:  ctl.branchOp = brGeu;
					default: begin
						ctl.aluOp   = aluAdd;
						ctl.illegal = 1'b1;
					end
				endcase
			end
			opLoad: begin
				ctl.srcBImm = 1'b1;
				ctl.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);  // LB..LHU.
			end
			opStore: begin
				ctl.srcBImm = 1'b1;
				ctl.imm     = immS;
				ctl.illegal = funct3[2] || (funct3[1:0] == 2'b11);  // SB, SH, SW.
			end
			default: ctl.illegal = 1'b1;  // Unknown opcode.
		endcase
	end

endmodule

//--- alu/alu.sv
`timescale 1ns/1ps

module alu (
	exCtlIf.consumer                   ctl,
	input  logic [rv32Pkg::xlen-1:0]   a,
	input  logic [rv32Pkg::xlen-1:0]   b,
	output logic [rv32Pkg::xlen-1:0]   aluOut,
	output logic                       condMet
);
	import rv32Pkg::*;

	logic [shamtW-1:0] shamt;
	logic              lessS;   // Signed a < b.
	logic              lessU;   // Unsigned a < b.
	logic              equal;

	assign shamt = b[shamtW-1:0];  // Upper bits of b ignored.
	assign lessS = $signed(a) < $signed(b);
	assign lessU = a < b;
	assign equal = a == b;

	//////////////////////////////////////////////////////////////////////
	// Result.
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctl.aluOp)
			aluAdd:   aluOut = a + b;  // Also AUIPC, loads, stores, JALR.
			aluSub:   aluOut = a - b;
			aluAnd:   aluOut = a & b;
			aluOr:    aluOut = a | b;
			aluXor:   aluOut = a ^ b;
			aluSlt:   aluOut = {{(xlen-1){1'b0}}, lessS};
			aluSltu:  aluOut = {{(xlen-1){1'b0}}, lessU};
			aluSll:   aluOut = a << shamt;
			aluSrl:   aluOut = a >> shamt;
			aluSra:   aluOut = $unsigned($signed(a) >>> shamt);
			aluPassB: aluOut = b;  // LUI.
			default:  aluOut = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Branch condition.
	//////////////////////////////////////////////////////////////////////

	// Direct compares of a and b, independent of aluOp.
	always_comb begin
		case (ctl.branchOp)
			brEq:    condMet = equal;
			brNe:    condMet = !equal;
			brLt:    condMet = lessS;
			brGe:    condMet = !lessS;
			brLtu:   condMet = lessU;
			brGeu:   condMet = !lessU;
			brJump:  condMet = 1'b1;  // Unconditional.
			default: condMet = 1'b0;  // brNone.
		endcase
	end

endmodule

//--- hw/resultStage.sv
`timescale 1ns/1ps

module resultStage (
	input  logic                       clk,
	input  logic                       arstN,
	exCtlIf.consumer                   ctl,
	input  logic                       inValid,
	input  logic [rv32Pkg::xlen-1:0]   pc,
	input  logic [rv32Pkg::xlen-1:0]   aluOut,
	input  logic                       condMet,
	output logic                       outValid,
	output logic [rv32Pkg::xlen-1:0]   result,
	output logic                       branchTaken,
	output logic [rv32Pkg::xlen-1:0]   target,
	output logic                       illegal
);
	import rv32Pkg::*;

	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] wbValue;     // Next result.
	logic [xlen-1:0] nextTarget;
	logic            takeNow;     // Next branchTaken.

	//////////////////////////////////////////////////////////////////////
	// Write-back value and target.
	//////////////////////////////////////////////////////////////////////

	assign pcPlus4 = pc + xlen'(4);

	// Link address for JAL and JALR.
	assign wbValue = ctl.linkPc ? pcPlus4 : aluOut;

	// JALR target is rs1 + imm from the ALU, LSB cleared.
	// Branches and JAL use their own adder on pc.
	assign nextTarget = ctl.jumpReg ? {aluOut[xlen-1:1], 1'b0}
	                                : pc + ctl.imm;

	assign takeNow = inValid && condMet && !ctl.illegal;

	//////////////////////////////////////////////////////////////////////
	// Output register.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid    <= 1'b0;
			branchTaken <= 1'b0;
			illegal     <= 1'b0;
			result      <= '0;
			target      <= '0;
		end else begin
			outValid    <= inValid;              // Drops on an idle cycle.
			branchTaken <= takeNow;
			illegal     <= inValid && ctl.illegal;
			if (inValid) begin                   // Hold payload when idle.
				result <= wbValue;
				target <= nextTarget;
			end
		end
	end

endmodule

//--- hw/execStage.sv
`timescale 1ns/1ps

module execStage (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       inValid,
	input  logic [rv32Pkg::xlen-1:0]   instr,
	input  logic [rv32Pkg::xlen-1:0]   pc,
	input  logic [rv32Pkg::xlen-1:0]   rs1Data,
	input  logic [rv32Pkg::xlen-1:0]   rs2Data,
	output logic                       outValid,
	output logic [rv32Pkg::xlen-1:0]   result,
	output logic                       branchTaken,
	output logic [rv32Pkg::xlen-1:0]   target,
	output logic                       illegal
);
	import rv32Pkg::*;

	exCtlIf ctl ();  // Decoded controls.

	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluOut;
	logic            condMet;

	// Decode, combinational.
	aluControl uDecode (
		.instr (instr),
		.ctl   (ctl)
	);

	// Operand muxing.
	assign opA = ctl.srcAPc ? pc : rs1Data;       // AUIPC, JAL.
	assign opB = ctl.srcBImm ? ctl.imm : rs2Data;

	alu uAlu (
		.ctl     (ctl),
		.a       (opA),
		.b       (opB),
		.aluOut  (aluOut),
		.condMet (condMet)
	);

	// One register stage to the outputs.
	resultStage uResult (
		.clk         (clk),
		.arstN       (arstN),
		.ctl         (ctl),
		.inValid     (inValid),
		.pc          (pc),
		.aluOut      (aluOut),
		.condMet     (condMet),
		.outValid    (outValid),
		.result      (result),
		.branchTaken (branchTaken),
		.target      (target),
		.illegal     (illegal)
	);

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ps

// Free-running clock and the power-on reset.
module clockGen #(
	parameter int halfPeriod  = 5,  // ns, so a 10 ns period.
	parameter int resetCycles = 8
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Released on a falling edge, after resetCycles rising edges.
	initial begin
		arstN = 1'b0;
		#(2 * halfPeriod * resetCycles) arstN = 1'b1;
	end

endmodule

//--- tb/execStageTb.sv
`timescale 1ns/1ps

module execStageTb;
	import rv32Pkg::*;

	localparam int maxCycles  = 2000;  // Tests take about 1200 cycles.
	localparam int pairsPerOp = 50;

	logic            clk;
	logic            arstN;
	logic            inValid;
	logic [xlen-1:0] instr;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1Data;
	logic [xlen-1:0] rs2Data;
	logic            outValid;
	logic [xlen-1:0] result;
	logic            branchTaken;
	logic [xlen-1:0] target;
	logic            illegal;

	int checks = 0;
	int errors = 0;
	int cycles = 0;

	// Expectation for the instruction now in the output register.
	logic            pending;
	logic            chkResult;   // Result defined for this kind.
	logic            chkTarget;   // Target defined for this kind.
	logic [xlen-1:0] expResult;
	logic [xlen-1:0] expTarget;
	logic            expTaken;
	logic            expIllegal;
	string           expLabel;

	clockGen #(.halfPeriod(5), .resetCycles(8)) uClock (.clk(clk), .arstN(arstN));

	execStage DUT (.*);

	//////////////////////////////////////////////////////////////////////
	// Reference model and encoders.
	//////////////////////////////////////////////////////////////////////

	// OP and OP-IMM result. alt is funct7 bit 5 where it counts.
	function automatic logic [xlen-1:0] arithRef(input logic [2:0] f3, input logic alt,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [4:0]      sh;
		logic [xlen-1:0] fill;  // Sign copies shifted in by SRA.
		sh = b[4:0];
		fill = a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0;
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << sh;
			3'd2:    return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			3'd3:    return {{(xlen-1){1'b0}}, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? (a >> sh) | fill : a >> sh;
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(input logic [2:0] f3, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;  // BGEU.
		endcase
	endfunction

	function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// rd x3, rs1 x1, rs2 x2 throughout.
	function automatic logic [31:0] rType(input logic alt, input logic [2:0] f3);
		return {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, opOp};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
			input opcodeE op);
		return {imm, 5'd1, f3, 5'd3, op};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, opJal};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driving and checking.
	//////////////////////////////////////////////////////////////////////

	task automatic compareValue(input string what, input logic [xlen-1:0] got,
			input logic [xlen-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Called on a falling edge, one rising edge after the last drive.
	task automatic checkOutputs();
		if (pending) begin
			compareValue({expLabel, " outValid"}, 32'(outValid), 32'd1);
			if (chkResult)
				compareValue({expLabel, " result"}, result, expResult);
			compareValue({expLabel, " branchTaken"}, 32'(branchTaken), 32'(expTaken));
			if (chkTarget)
				compareValue({expLabel, " target"}, target, expTarget);
			compareValue({expLabel, " illegal"}, 32'(illegal), 32'(expIllegal));
		end else begin
			compareValue("idle outValid", 32'(outValid), 32'd0);
			compareValue("idle branchTaken", 32'(branchTaken), 32'd0);
		end
	endtask

	// Checks the previous instruction, then drives the next one.
	task automatic issue(input logic [31:0] ins, input logic [xlen-1:0] pcIn,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b, input string label,
			input logic doResult, input logic [xlen-1:0] res, input logic taken,
			input logic doTarget, input logic [xlen-1:0] tgt, input logic ill);
		@(negedge clk);
		checkOutputs();
		inValid = 1'b1;
		instr = ins;
		pc = pcIn;
		rs1Data = a;
		rs2Data = b;
		pending = 1'b1;
		expLabel = label;
		chkResult = doResult;
		expResult = res;
		expTaken = taken;
		chkTarget = doTarget;
		expTarget = tgt;
		expIllegal = ill;
	endtask

	task automatic idle();
		@(negedge clk);
		checkOutputs();
		inValid = 1'b0;
		pending = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests.
	//////////////////////////////////////////////////////////////////////

	// OP over all funct3 plus SUB and SRA, then OP-IMM plus SRAI.
	task automatic testRegArith();
		logic            isImm;
		logic            alt;
		logic [2:0]      f3;
		logic [11:0]     imm;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		int              k;
		for (int v = 0; v < 19; v++) begin
			isImm = v >= 10;
			k = isImm ? v - 10 : v;
			alt = k >= 8;
			f3 = (k == 8 && !isImm) ? 3'd0 : (k >= 8 ? 3'd5 : 3'(k));
			for (int i = 0; i < pairsPerOp; i++) begin
				a = $urandom();
				b = $urandom();  // Upper bits must not reach the shifter.
				imm = 12'($urandom());
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {1'b0, alt, 5'd0, imm[4:0]};  // Shift immediate form.
				issue(isImm ? iType(imm, f3, opImm) : rType(alt, f3), $urandom(), a, b,
					$sformatf("%s f3 %0d alt %0d", isImm ? "OP-IMM" : "OP", f3, alt),
					1'b1, arithRef(f3, alt, a, isImm ? sext12(imm) : b),
					1'b0, 1'b0, '0, 1'b0);
			end
		end
	endtask

	task automatic testUpperMem();
		logic [xlen-1:0] a;
		logic [xlen-1:0] pcV;
		logic [19:0]     up;
		logic [11:0]     off;
		logic [2:0]      f3;
		for (int i = 0; i < 10; i++) begin
			a = $urandom();
			pcV = $urandom();
			up = 20'($urandom());
			off = 12'($urandom());
			issue({up, 5'd3, opLui}, pcV, a, a, "LUI", 1'b1, {up, 12'd0},
				1'b0, 1'b0, '0, 1'b0);
			issue({up, 5'd3, opAuipc}, pcV, a, a, "AUIPC", 1'b1, pcV + {up, 12'd0},
				1'b0, 1'b0, '0, 1'b0);
			f3 = 3'($urandom_range(4));
			f3 = (f3 >= 3'd3) ? f3 + 3'd1 : f3;  // LB LH LW LBU LHU.
			issue(iType(off, f3, opLoad), pcV, a, a, "load", 1'b1, a + sext12(off),
				1'b0, 1'b0, '0, 1'b0);
			f3 = 3'($urandom_range(2));
			issue({off[11:5], 5'd2, 5'd1, f3, off[4:0], opStore}, pcV, a, $urandom(),
				"store", 1'b1, a + sext12(off), 1'b0, 1'b0, '0, 1'b0);
		end
	endtask

	task automatic testBranches();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] pcV;
		logic [12:0]     off;
		for (int c = 0; c < 8; c++) begin
			if (c == 2 || c == 3)
				continue;  // No branch here.
			for (int i = 0; i < 22; i++) begin
				a = $urandom();
				b = (i < 2) ? a : $urandom();  // Equal pair first.
				pcV = $urandom();
				off = {12'($urandom()), 1'b0};
				issue(bType(off, 3'(c)), pcV, a, b, $sformatf("branch f3 %0d", c), 1'b0, '0,
					branchRef(3'(c), a, b), 1'b1, pcV + {{19{off[12]}}, off}, 1'b0);
			end
		end
	endtask

	task automatic testJumps();
		logic [xlen-1:0] a;
		logic [xlen-1:0] pcV;
		logic [xlen-1:0] tgt;
		logic [20:0]     jOff;
		logic [11:0]     off;
		for (int i = 0; i < 10; i++) begin
			a = $urandom();
			pcV = $urandom();
			jOff = {20'($urandom()), 1'b0};
			off = 12'($urandom());
			issue(jType(jOff), pcV, a, a, "JAL", 1'b1, pcV + 32'd4, 1'b1,
				1'b1, pcV + {{11{jOff[20]}}, jOff}, 1'b0);
			tgt = a + sext12(off);
			tgt[0] = 1'b0;  // JALR drops the LSB.
			issue(iType(off, 3'd0, opJalr), pcV, a, a, "JALR", 1'b1, pcV + 32'd4, 1'b1,
				1'b1, tgt, 1'b0);
		end
	endtask

	// Idle cycles and illegal encodings. The other tests already run back to back.
	task automatic testPipeIllegal();
		logic [6:0]      badOps [5];
		logic [xlen-1:0] a;
		badOps = '{7'b0000000, 7'b0001111, 7'b1110011, 7'b0101011, 7'b1111111};
		a = $urandom();
		issue(jType(21'd64), 32'h100, a, a, "JAL before idle", 1'b1, 32'h104, 1'b1,
			1'b1, 32'h140, 1'b0);
		idle();  // Taken flag must not linger.
		issue(rType(1'b0, 3'd0), $urandom(), a, a, "ADD after idle", 1'b1, a + a,
			1'b0, 1'b0, '0, 1'b0);
		foreach (badOps[i])
			issue({25'($urandom()), badOps[i]}, $urandom(), a, a, "unknown opcode",
				1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
		// Unknown funct3. Equal operands would take a misread BEQ.
		issue(bType(13'd8, 3'd2), 32'h200, a, a, "branch f3 2", 1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
		issue(bType(13'd8, 3'd3), 32'h204, a, a, "branch f3 3", 1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
		issue(iType(12'd4, 3'd1, opJalr), 32'h208, a, a, "JALR f3 1", 1'b0, '0, 1'b0,
			1'b0, '0, 1'b1);
		issue(iType(12'd4, 3'd3, opLoad), 32'h20c, a, a, "load f3 3", 1'b0, '0, 1'b0,
			1'b0, '0, 1'b1);
		idle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run.
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hcb43_fc58));
		inValid = 1'b0;
		instr = '0;
		pc = '0;
		rs1Data = '0;
		rs2Data = '0;
		pending = 1'b0;
		repeat (4) begin  // Inside the reset window.
			@(negedge clk);
			compareValue("reset outValid", 32'(outValid), 32'd0);
			compareValue("reset branchTaken", 32'(branchTaken), 32'd0);
			compareValue("reset illegal", 32'(illegal), 32'd0);
			compareValue("reset result", result, '0);
			compareValue("reset target", target, '0);
		end
		wait (arstN === 1'b1);
		idle();  // Next check sees outValid after reset.
		testRegArith();
		testUpperMem();
		testBranches();
		testJumps();
		testPipeIllegal();
		idle();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- project.f
common/rv32Pkg.sv
common/exCtlIf.sv
hw/aluControl.sv
alu/alu.sv
hw/resultStage.sv
hw/execStage.sv
tb/clockGen.sv
tb/execStageTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := execStageTb
FILELIST := project.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
